// ==== rp_pkg.sv ====
`default_nettype none

package rp_pkg;

  ////////////////////////////////////////////////////////////////////
  // converter widths and sample types
  ////////////////////////////////////////////////////////////////////

  localparam int ADC_RAW_W = 16;  // adc pin word, two low bits reserved
  localparam int SAMPLE_W  = 14;  // converter resolution

  typedef logic signed [SAMPLE_W-1:0] sample_t;  // two's complement
  typedef logic        [SAMPLE_W-1:0] raw_t;     // offset, negative slope

  typedef struct packed {
    sample_t ch_a;
    sample_t ch_b;
  } sample_pair_t;

  typedef struct packed {
    raw_t ch_a;
    raw_t ch_b;
  } raw_pair_t;

  typedef struct packed {
    logic [ADC_RAW_W-1:0] ch_a;
    logic [ADC_RAW_W-1:0] ch_b;
  } adc_raw_pair_t;

  ////////////////////////////////////////////////////////////////////
  // system bus, region map and housekeeping offsets
  ////////////////////////////////////////////////////////////////////

  localparam int N_REGIONS  = 8;   // 1 MiB each
  localparam int REGION_LSB = 20;  // region index on addr 22..20

  typedef logic [2:0] region_t;

  localparam region_t HK_REGION = 3'd0;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  sel;    // byte select
    logic        wen;    // single-cycle write strobe
    logic        ren;    // single-cycle read strobe
  } sys_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
    logic        ack;
  } sys_rsp_t;

  // offsets inside a region, addr 19..0
  localparam logic [REGION_LSB-1:0] HK_OFS_ID   = 20'h00000;
  localparam logic [REGION_LSB-1:0] HK_OFS_LOOP = 20'h00004;
  localparam logic [REGION_LSB-1:0] HK_OFS_LED  = 20'h00030;

  localparam logic [31:0] HK_ID_VALUE = 32'h5250_0001;  // board id word

endpackage

`default_nettype wire

// ==== rp_sys_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rp_sys_ctrl
  import rp_pkg::*;
(
  input  wire      adc_clk,
  input  wire      rst_n_i,       // external reset, active low
  input  wire      pll_locked_i,
  input  sys_req_t sys_req_i,     // from bus master
  input  sys_rsp_t hk_rsp_i,      // region 0 answer
  output logic     core_rst_n_o,
  output sys_req_t hk_req_o,      // strobes gated to region 0
  output sys_rsp_t sys_rsp_o
);

  ////////////////////////////////////////////////////////////////////
  // reset conditioning
  ////////////////////////////////////////////////////////////////////

  logic [1:0] rst_sync;  // two stage release

  // async assert from pin, lock loss clears both stages at once
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rst_sync <= 2'b00;
    else if (!pll_locked_i)
      rst_sync <= 2'b00;  // assert on next edge
    else
      rst_sync <= {rst_sync[0], 1'b1};
  end

  assign core_rst_n_o = rst_sync[1];

  ////////////////////////////////////////////////////////////////////
  // region decode and response mux
  ////////////////////////////////////////////////////////////////////

  region_t              region;
  logic [N_REGIONS-1:0] region_cs;  // one-hot chip select

  assign region    = sys_req_i.addr[REGION_LSB +: $bits(region_t)];
  assign region_cs = N_REGIONS'(1) << region;

  // address and data pass through, strobes only when hk is selected
  always_comb
  begin
    hk_req_o     = sys_req_i;
    hk_req_o.wen = sys_req_i.wen & region_cs[HK_REGION];
    hk_req_o.ren = sys_req_i.ren & region_cs[HK_REGION];
  end

  always_comb
  begin
    if (region_cs[HK_REGION])
      sys_rsp_o = hk_rsp_i;
    else
    begin
      // regions 1..7 unpopulated, ack right away with zero data
      sys_rsp_o.rdata = '0;
      sys_rsp_o.err   = 1'b0;
      sys_rsp_o.ack   = 1'b1;
    end
  end

  // hk ack always traces back to a routed strobe one cycle earlier
  a_hk_ack_after_strobe : assert property (
    @(posedge adc_clk) disable iff (!core_rst_n_o)
    hk_rsp_i.ack |-> $past(hk_req_o.wen | hk_req_o.ren)
  );

endmodule

`default_nettype wire

// ==== rp_hk_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module rp_hk_regs
  import rp_pkg::*;
(
  input  wire        adc_clk,
  input  wire        core_rst_n_i,
  input  sys_req_t   hk_req_i,        // strobes already gated to region 0
  output sys_rsp_t   hk_rsp_o,
  output logic       digital_loop_o,  // dac samples into adc path
  output logic [7:0] led_o
);

  logic [REGION_LSB-1:0] ofs;
  logic                  strobe;
  logic                  ofs_hit;  // one of the three mapped words
  logic [31:0]           rd_mux;

  assign ofs    = hk_req_i.addr[REGION_LSB-1:0];
  assign strobe = hk_req_i.wen | hk_req_i.ren;

  // offset decode and read mux
  always_comb
  begin
    ofs_hit = 1'b1;
    rd_mux  = '0;
    case (ofs)
      HK_OFS_ID   : rd_mux = HK_ID_VALUE;
      HK_OFS_LOOP : rd_mux = {31'd0, digital_loop_o};
      HK_OFS_LED  : rd_mux = {24'd0, led_o};
      default     : ofs_hit = 1'b0;  // unmapped, zero data with err
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // writable registers
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge core_rst_n_i)
  begin
    if (!core_rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= 8'h00;
    end
    else if (hk_req_i.wen)
    begin
      if (ofs == HK_OFS_LOOP)
        digital_loop_o <= hk_req_i.wdata[0];
      if (ofs == HK_OFS_LED)
        led_o <= hk_req_i.wdata[7:0];
      // id is read-only, writes there are dropped
    end
  end

  // response, one cycle after the strobe
  always_ff @(posedge adc_clk or negedge core_rst_n_i)
  begin
    if (!core_rst_n_i)
      hk_rsp_o <= '0;
    else
    begin
      hk_rsp_o.ack   <= strobe;
      hk_rsp_o.err   <= strobe & ~ofs_hit;
      hk_rsp_o.rdata <= hk_req_i.ren ? rd_mux : 32'd0;  // zero unless read
    end
  end

  // bus master must never strobe read and write together
  a_no_rw_overlap : assert property (
    @(posedge adc_clk) disable iff (!core_rst_n_i)
    !(hk_req_i.wen && hk_req_i.ren)
  );

endmodule

`default_nettype wire

// ==== rp_adc_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module rp_adc_frontend
  import rp_pkg::*;
(
  input  wire           adc_clk,
  input  wire           core_rst_n_i,
  input  adc_raw_pair_t adc_dat_i,       // pin words, 2 lsbs reserved
  input  sample_pair_t  dac_smp_i,       // loopback source
  input  wire           digital_loop_i,
  output sample_pair_t  adc_smp_o
);

  raw_pair_t    adc_reg;  // input registers, pin coding
  sample_pair_t adc_cnv;

  ////////////////////////////////////////////////////////////////////
  // capture, top 14 bits only
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge core_rst_n_i)
  begin
    if (!core_rst_n_i)
      adc_reg <= '0;
    else
    begin
      adc_reg.ch_a <= adc_dat_i.ch_a[ADC_RAW_W-1 -: SAMPLE_W];
      adc_reg.ch_b <= adc_dat_i.ch_b[ADC_RAW_W-1 -: SAMPLE_W];
    end
  end

  // negative slope offset code to two's complement
  assign adc_cnv.ch_a = {adc_reg.ch_a[SAMPLE_W-1], ~adc_reg.ch_a[SAMPLE_W-2:0]};
  assign adc_cnv.ch_b = {adc_reg.ch_b[SAMPLE_W-1], ~adc_reg.ch_b[SAMPLE_W-2:0]};

  // loopback bypasses the capture registers
  assign adc_smp_o = digital_loop_i ? dac_smp_i : adc_cnv;

endmodule

`default_nettype wire

// ==== rp_dac_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module rp_dac_frontend
  import rp_pkg::*;
(
  input  wire          adc_clk,
  input  wire          core_rst_n_i,
  input  sample_pair_t dac_smp_i,    // two's complement in
  output raw_pair_t    dac_dat_o,    // pin coding out
  output logic         dac_rst_o     // converter reset, active high
);

  raw_pair_t dac_cnv;

  ////////////////////////////////////////////////////////////////////
  // code conversion and output register
  ////////////////////////////////////////////////////////////////////

  // sign kept, magnitude bits flipped for negative slope
  assign dac_cnv.ch_a = {dac_smp_i.ch_a[SAMPLE_W-1], ~dac_smp_i.ch_a[SAMPLE_W-2:0]};
  assign dac_cnv.ch_b = {dac_smp_i.ch_b[SAMPLE_W-1], ~dac_smp_i.ch_b[SAMPLE_W-2:0]};

  always_ff @(posedge adc_clk or negedge core_rst_n_i)
  begin
    if (!core_rst_n_i)
      dac_dat_o <= '0;  // quiet pins in reset
    else
      dac_dat_o <= dac_cnv;
  end

  // follows core reset without delay
  assign dac_rst_o = ~core_rst_n_i;

  // converter never sees data while held in reset
  a_dac_quiet_in_rst : assert property (
    @(posedge adc_clk)
    dac_rst_o |-> (dac_dat_o == '0)
  );

endmodule

`default_nettype wire

// ==== rp_analog_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rp_analog_top
  import rp_pkg::*;
(
  input  wire           adc_clk,
  input  wire           rst_n_i,
  input  wire           pll_locked_i,
  // register bus
  input  sys_req_t      sys_req_i,
  output sys_rsp_t      sys_rsp_o,
  // converters
  input  adc_raw_pair_t adc_dat_i,
  input  sample_pair_t  dac_smp_i,     // from outside, replaces dsp
  output sample_pair_t  adc_smp_o,
  output raw_pair_t     dac_dat_o,
  output logic          dac_rst_o,
  // board
  output logic [7:0]    led_o
);

  logic     core_rst_n;
  sys_req_t hk_req;       // region 0 request
  sys_rsp_t hk_rsp;
  logic     digital_loop;

  ////////////////////////////////////////////////////////////////////
  // reset and bus fabric
  ////////////////////////////////////////////////////////////////////

  rp_sys_ctrl i_sys_ctrl (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .pll_locked_i (pll_locked_i),
    .sys_req_i    (sys_req_i),
    .hk_rsp_i     (hk_rsp),
    .core_rst_n_o (core_rst_n),
    .hk_req_o     (hk_req),
    .sys_rsp_o    (sys_rsp_o)
  );

  // housekeeping, region 0
  rp_hk_regs i_hk (
    .adc_clk        (adc_clk),
    .core_rst_n_i   (core_rst_n),
    .hk_req_i       (hk_req),
    .hk_rsp_o       (hk_rsp),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  ////////////////////////////////////////////////////////////////////
  // analog datapath
  ////////////////////////////////////////////////////////////////////

  rp_adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .core_rst_n_i   (core_rst_n),
    .adc_dat_i      (adc_dat_i),
    .dac_smp_i      (dac_smp_i),     // loopback tap
    .digital_loop_i (digital_loop),
    .adc_smp_o      (adc_smp_o)
  );

  rp_dac_frontend i_dac (
    .adc_clk      (adc_clk),         // single domain, dac runs on adc clock
    .core_rst_n_i (core_rst_n),
    .dac_smp_i    (dac_smp_i),
    .dac_dat_o    (dac_dat_o),
    .dac_rst_o    (dac_rst_o)
  );

endmodule

`default_nettype wire

// ==== tb_rp_analog_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rp_analog_top
  import rp_pkg::*;
();

  localparam logic [1:0] STEP_WR  = 2'd0;
  localparam logic [1:0] STEP_RD  = 2'd1;
  localparam logic [1:0] STEP_SMP = 2'd2;
  localparam int N_STEPS     = 32;
  localparam int TIMEOUT_CYC = N_STEPS * 4 + 50;  // bus step takes 3 cycles at most
  localparam int ACK_WAIT    = 3;

  typedef struct packed {
    logic [1:0]    kind;
    logic [31:0]   addr;
    logic [31:0]   wdata;
    logic [31:0]   exp_rdata;
    logic          exp_err;
    adc_raw_pair_t adc;        // sample steps only
    sample_pair_t  dac;
  } step_t;

  logic          adc_clk;
  logic          rst_n_i;
  logic          pll_locked_i;
  sys_req_t      sys_req_i;
  sys_rsp_t      sys_rsp_o;
  adc_raw_pair_t adc_dat_i;
  sample_pair_t  dac_smp_i;
  sample_pair_t  adc_smp_o;
  raw_pair_t     dac_dat_o;
  logic          dac_rst_o;
  logic [7:0]    led_o;

  step_t       steps [N_STEPS];
  int          n_fill     = 0;
  int          cycle_cnt  = 0;
  logic [31:0] lcg_state  = 32'd49853;
  logic [7:0]  led_model  = 8'h00;  // expected register state
  logic        loop_model = 1'b0;

  rp_analog_top UUT (.*);  // port names match one to one

  initial
  begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;  // 25 MHz
  end

  always @(posedge adc_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC)
      abort_run("timeout, the test sequence did not finish within the cycle limit");
  end

  //////////////////////////////////////////////////////////////////////
  // reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("[ERROR] %0t ns %s", $time, msg));
  endtask

  task automatic check_rsp(input sys_rsp_t got, input sys_rsp_t exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s: rdata %h err %b ack %b, expected %h %b %b",
        what, got.rdata, got.err, got.ack, exp.rdata, exp.err, exp.ack));
  endtask

  task automatic check_smp(input sample_pair_t got, input sample_pair_t exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s: got a %h b %h, expected a %h b %h",
        what, got.ch_a, got.ch_b, exp.ch_a, exp.ch_b));
  endtask

  task automatic check_raw(input raw_pair_t got, input raw_pair_t exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s: got a %h b %h, expected a %h b %h",
        what, got.ch_a, got.ch_b, exp.ch_a, exp.ch_b));
  endtask

  task automatic check_bits(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference rules and stimulus table
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // msb stays, the 13 bits below flip
  function automatic sample_t adc_expect(input logic [ADC_RAW_W-1:0] pin);
    return sample_t'(pin[ADC_RAW_W-1:2] ^ {1'b0, {(SAMPLE_W-1){1'b1}}});
  endfunction

  function automatic raw_t dac_expect(input sample_t smp);
    return raw_t'(smp ^ {1'b0, {(SAMPLE_W-1){1'b1}}});
  endfunction

  task automatic add_bus(input logic [1:0] kind, input region_t rgn, input logic [19:0] ofs,
                         input logic [31:0] wdata, input logic [31:0] rdata, input logic err);
    step_t s;
    s           = '0;
    s.kind      = kind;
    s.addr      = {9'd0, rgn, ofs};
    s.wdata     = wdata;
    s.exp_rdata = rdata;
    s.exp_err   = err;
    steps[n_fill] = s;
    n_fill++;
  endtask

  task automatic add_smp();
    step_t       s;
    logic [31:0] r;
    s      = '0;
    s.kind = STEP_SMP;
    s.adc  = lcg_next();
    r      = lcg_next();
    s.dac  = {r[31:18], r[15:2]};
    steps[n_fill] = s;
    n_fill++;
  endtask

  task automatic build_table();
    add_bus(STEP_RD, 3'd0, HK_OFS_ID, 32'd0, HK_ID_VALUE, 1'b0);
    repeat (3) add_smp();
    add_bus(STEP_WR, 3'd0, HK_OFS_LED, 32'h0000_00a5, 32'd0, 1'b0);
    add_bus(STEP_RD, 3'd0, HK_OFS_LED, 32'd0, 32'h0000_00a5, 1'b0);
    add_bus(STEP_RD, 3'd0, HK_OFS_LOOP, 32'd0, 32'd0, 1'b0);
    // unmapped words in region 0
    add_bus(STEP_WR, 3'd0, 20'h00008, 32'hffff_ffff, 32'd0, 1'b1);
    add_bus(STEP_RD, 3'd0, 20'h00008, 32'd0, 32'd0, 1'b1);
    add_bus(STEP_RD, 3'd0, 20'h00034, 32'd0, 32'd0, 1'b1);
    // empty regions, must not touch hk
    add_bus(STEP_WR, 3'd1, HK_OFS_LED, 32'h0000_00ff, 32'd0, 1'b0);
    add_bus(STEP_RD, 3'd3, HK_OFS_ID, 32'd0, 32'd0, 1'b0);
    add_bus(STEP_WR, 3'd7, HK_OFS_LOOP, 32'd1, 32'd0, 1'b0);
    add_bus(STEP_RD, 3'd5, HK_OFS_LED, 32'd0, 32'd0, 1'b0);
    add_bus(STEP_RD, 3'd0, HK_OFS_LED, 32'd0, 32'h0000_00a5, 1'b0);
    add_smp();
    add_bus(STEP_WR, 3'd0, HK_OFS_LOOP, 32'd1, 32'd0, 1'b0);
    add_bus(STEP_RD, 3'd0, HK_OFS_LOOP, 32'd0, 32'd1, 1'b0);
    repeat (3) add_smp();
    add_bus(STEP_WR, 3'd0, HK_OFS_LED, 32'h0000_003c, 32'd0, 1'b0);
    add_bus(STEP_RD, 3'd0, HK_OFS_LED, 32'd0, 32'h0000_003c, 1'b0);
    add_bus(STEP_WR, 3'd0, HK_OFS_LOOP, 32'd0, 32'd0, 1'b0);
    repeat (2) add_smp();
    add_bus(STEP_RD, 3'd2, HK_OFS_ID, 32'd0, 32'd0, 1'b0);
    add_bus(STEP_WR, 3'd4, HK_OFS_LED, 32'h0000_0081, 32'd0, 1'b0);
    add_bus(STEP_RD, 3'd6, HK_OFS_LOOP, 32'd0, 32'd0, 1'b0);
    add_bus(STEP_RD, 3'd0, HK_OFS_ID, 32'd0, HK_ID_VALUE, 1'b0);
    repeat (2) add_smp();
  endtask

  //////////////////////////////////////////////////////////////////////
  // step execution
  //////////////////////////////////////////////////////////////////////

  task automatic bus_access(input step_t s);
    sys_rsp_t got;
    int       lat;
    int       exp_lat;
    region_t  rgn;
    rgn     = s.addr[REGION_LSB +: 3];
    exp_lat = (rgn == HK_REGION) ? 1 : 0;  // hk registers, others answer at once
    lat     = 0;
    @(posedge adc_clk);
    sys_req_i.addr  <= s.addr;
    sys_req_i.wdata <= s.wdata;
    sys_req_i.sel   <= 4'hf;
    sys_req_i.wen   <= (s.kind == STEP_WR);
    sys_req_i.ren   <= (s.kind == STEP_RD);
    @(negedge adc_clk);
    while (!sys_rsp_o.ack && lat < ACK_WAIT)
    begin
      @(posedge adc_clk);
      sys_req_i.wen <= 1'b0;  // single cycle strobe
      sys_req_i.ren <= 1'b0;
      @(negedge adc_clk);
      lat++;
    end
    if (!sys_rsp_o.ack)
      abort_run("a bus access was never acknowledged");
    got = sys_rsp_o;
    if (s.kind == STEP_WR && rgn == HK_REGION)
      got.rdata = '0;  // region 0 rdata only defined for reads
    check_rsp(got, {s.exp_rdata, s.exp_err, 1'b1}, "bus response");
    check_bits(8'(lat), 8'(exp_lat), "ack latency in cycles");
    if (lat == 0)
    begin
      @(posedge adc_clk);
      sys_req_i.wen <= 1'b0;
      sys_req_i.ren <= 1'b0;
      @(negedge adc_clk);
    end
    if (s.kind == STEP_WR && rgn == HK_REGION && !s.exp_err)
    begin
      if (s.addr[19:0] == HK_OFS_LED)
        led_model = s.wdata[7:0];
      if (s.addr[19:0] == HK_OFS_LOOP)
        loop_model = s.wdata[0];
    end
    check_bits(led_o, led_model, "led_o after bus access");
  endtask

  task automatic sample_step(input adc_raw_pair_t adc, input sample_pair_t dac);
    sample_pair_t exp_adc;
    raw_pair_t    exp_dac;
    exp_adc.ch_a = adc_expect(adc.ch_a);
    exp_adc.ch_b = adc_expect(adc.ch_b);
    exp_dac.ch_a = dac_expect(dac.ch_a);
    exp_dac.ch_b = dac_expect(dac.ch_b);
    @(posedge adc_clk);
    adc_dat_i <= adc;
    dac_smp_i <= dac;
    @(negedge adc_clk);
    if (loop_model)
      check_smp(adc_smp_o, dac, "loopback in the same cycle");
    @(negedge adc_clk);  // one register stage later
    check_smp(adc_smp_o, loop_model ? dac : exp_adc, "adc sample path");
    check_raw(dac_dat_o, exp_dac, "dac conversion");
  endtask

  initial
  begin
    rst_n_i      = 1'b0;
    pll_locked_i = 1'b0;
    sys_req_i    = '0;
    adc_dat_i    = '0;
    dac_smp_i    = '0;
    build_table();
    repeat (4) @(posedge adc_clk);
    rst_n_i   <= 1'b1;
    dac_smp_i <= {14'sh0155, 14'sh3aaa};  // nonzero, must stay off the pins
    repeat (2) @(negedge adc_clk);
    check_bits({7'd0, dac_rst_o}, 8'd1, "dac_rst_o before lock");
    check_raw(dac_dat_o, '0, "dac_dat_o before lock");
    check_bits(led_o, 8'h00, "led_o before lock");
    @(posedge adc_clk);
    pll_locked_i <= 1'b1;
    repeat (2) @(negedge adc_clk);
    check_bits({7'd0, dac_rst_o}, 8'd1, "dac_rst_o one cycle after lock");
    @(negedge adc_clk);
    check_bits({7'd0, dac_rst_o}, 8'd0, "dac_rst_o two cycles after lock");
    for (int i = 0; i < N_STEPS; i++)
    begin
      if (steps[i].kind == STEP_SMP)
        sample_step(steps[i].adc, steps[i].dac);
      else
        bus_access(steps[i]);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
rp_pkg.sv
rp_sys_ctrl.sv
rp_hk_regs.sv
rp_adc_frontend.sv
rp_dac_frontend.sv
rp_analog_top.sv
tb_rp_analog_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rp_analog_top -f project.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
